// ==== src/sd_bus_pkg.sv ====
/* Bus-side types for the SD transmit framer: word and lane widths, lane modes,
   framer states and the structs passed between its stages. */

package sd_bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_BITS = 32;
	localparam int LANE_BITS = 8;

	// One stream word, and one group driven onto the data lines
	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [LANE_BITS-1:0] lanes_t;

	// Idle lines sit high
	localparam word_t IDLE_WORD = '1;

	////////////////////////////////////////////////////////////////////////////
	// Modes and states
	////////////////////////////////////////////////////////////////////////////

	// Code 2'b11 is not a legal width, treated as eight lines
	typedef enum logic [1:0] {
		WIDTH_1 = 2'b00,
		WIDTH_4 = 2'b01,
		WIDTH_8 = 2'b10
	} lane_width_e;

	typedef enum logic [1:0] {
		ST_IDLE = 2'b00,
		ST_DATA = 2'b01,
		ST_CRC  = 2'b10,
		ST_LAST = 2'b11
	} frame_state_e;

	////////////////////////////////////////////////////////////////////////////
	// Stage interfaces
	////////////////////////////////////////////////////////////////////////////

	// Frame configuration, held for the whole frame
	typedef struct packed {
		lane_width_e width;
	} tx_cfg_t;

	// Word handed from the packetizer to the serializer
	typedef struct packed {
		logic  valid;
		logic  start;
		logic  half;	// Only the upper 16 bits go out
		word_t data;
	} pre_word_t;

endpackage

// ==== src/sd_crc_pkg.sv ====
/* CRC-16 definitions for the SD data lines, with the one-bit step shared by
   the CRC bank and the testbench reference model. */

package sd_crc_pkg;

	localparam int CRC_BITS  = 16;
	localparam int MAX_LANES = 8;

	// One line's CRC
	typedef logic [CRC_BITS-1:0] crc_t;

	// CRCs of all lines, bit-interleaved in the order they leave the bus
	typedef logic [CRC_BITS*MAX_LANES-1:0] crc_bank_t;

	// x^16 + x^12 + x^5 + 1
	localparam crc_t CRC_POLY = 16'h1021;

	////////////////////////////////////////////////////////////////////////////
	// Single bit update
	////////////////////////////////////////////////////////////////////////////

	// Feeds one data bit into the CRC, MSB of the fill leaves first
	function automatic crc_t crc_step(
		input crc_t prior,
		input logic bit_in
	);
		crc_t shifted;

		shifted = {prior[CRC_BITS-2:0], 1'b0};
		if (prior[CRC_BITS-1] ^ bit_in)
			return shifted ^ CRC_POLY;
		else
			return shifted;
	endfunction

endpackage

// ==== src/sd_tx_packetizer.sv ====
/* Frame sequencer of the SD transmit path. Accepts stream words, latches the
   lane width per frame and appends the CRC words once the last word is in. */

`timescale 1ns/1ps

module sd_tx_packetizer (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  sd_bus_pkg::lane_width_e i_cfg_width,
	input  logic                    i_en,
	input  logic                    i_s_valid,
	input  sd_bus_pkg::word_t       i_s_data,
	input  logic                    i_s_last,
	input  logic                    i_pre_ready,
	input  logic                    i_line_busy,
	input  sd_bus_pkg::word_t       i_crc_word,
	output logic                    o_s_ready,
	output sd_bus_pkg::tx_cfg_t     o_cfg,
	output sd_bus_pkg::pre_word_t   o_pre,
	output logic                    o_crc_clear,
	output logic                    o_crc_advance,
	output logic                    o_crc_shift
);

	sd_bus_pkg::frame_state_e state;
	sd_bus_pkg::tx_cfg_t      cfg_q;
	logic                     pre_valid;
	logic                     pre_half;
	sd_bus_pkg::word_t        pre_data;
	logic [1:0]               crc_left;
	logic                     start_frame;
	logic                     accept;
	logic                     crc_take;

	////////////////////////////////////////////////////////////////////////////
	// Handshakes
	////////////////////////////////////////////////////////////////////////////

	// A frame opens only on a strobe with the line quiet
	assign start_frame = (state == sd_bus_pkg::ST_IDLE) && i_en && i_s_valid
		&& i_pre_ready && !i_line_busy;

	always_comb begin
		case (state)
		sd_bus_pkg::ST_IDLE: o_s_ready = i_pre_ready && i_en && !i_line_busy;
		sd_bus_pkg::ST_DATA: o_s_ready = i_pre_ready;
		default:             o_s_ready = 1'b0;
		endcase
	end

	assign accept   = i_s_valid && o_s_ready;
	assign crc_take = i_pre_ready && (state == sd_bus_pkg::ST_CRC);

	assign o_crc_clear   = start_frame;
	assign o_crc_advance = accept;
	assign o_crc_shift   = crc_take;

	assign o_cfg = cfg_q;
	assign o_pre = '{valid: pre_valid, start: start_frame, half: pre_half, data: pre_data};

	////////////////////////////////////////////////////////////////////////////
	// Frame state machine
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			state     <= sd_bus_pkg::ST_IDLE;
			cfg_q     <= '{width: sd_bus_pkg::WIDTH_1};
			pre_valid <= 1'b0;
			pre_half  <= 1'b0;
		end else begin
			case (state)
			sd_bus_pkg::ST_IDLE: begin
				// Width is frozen from the start strobe on
				if (start_frame) begin
					state     <= i_s_last ? sd_bus_pkg::ST_CRC : sd_bus_pkg::ST_DATA;
					pre_valid <= 1'b1;
					pre_half  <= 1'b0;
				end else begin
					cfg_q.width <= i_cfg_width;
				end
			end
			sd_bus_pkg::ST_DATA: begin
				if (accept && i_s_last)
					state <= sd_bus_pkg::ST_CRC;
			end
			sd_bus_pkg::ST_CRC: begin
				if (crc_take) begin
					pre_valid <= 1'b1;
					// Single line sends one 16-bit CRC only
					pre_half  <= (cfg_q.width == sd_bus_pkg::WIDTH_1);
					if (crc_left == 2'd0)
						state <= sd_bus_pkg::ST_LAST;
				end
			end
			default: begin
				if (i_pre_ready) begin
					pre_valid <= 1'b0;
					pre_half  <= 1'b0;
				end
				// Stop group is out once the line drops
				if (!i_line_busy)
					state <= sd_bus_pkg::ST_IDLE;
			end
			endcase
		end
	end

	// CRC words still to send after the current one
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			crc_left <= 2'd0;
		end else if (state == sd_bus_pkg::ST_IDLE || state == sd_bus_pkg::ST_DATA) begin
			case (cfg_q.width)
			sd_bus_pkg::WIDTH_1: crc_left <= 2'd0;
			sd_bus_pkg::WIDTH_4: crc_left <= 2'd1;
			default:             crc_left <= 2'd3;
			endcase
		end else if (crc_take && crc_left != 2'd0) begin
			crc_left <= crc_left - 2'd1;
		end
	end

	// Pending word, data first and then the CRC words
	always_ff @(posedge i_clk) begin
		if (accept)
			pre_data <= i_s_data;
		else if (crc_take)
			pre_data <= i_crc_word;
	end

endmodule

// ==== src/sd_tx_crc_bank.sv ====
/* Per-line CRC-16 generator. Steps every line's CRC on each accepted word and
   hands the results out 32 interleaved bits at a time. */

`timescale 1ns/1ps

module sd_tx_crc_bank (
	input  logic                i_clk,
	input  logic                i_reset,
	input  sd_bus_pkg::tx_cfg_t i_cfg,
	input  logic                i_clear,
	input  logic                i_advance,
	input  logic                i_shift,
	input  sd_bus_pkg::word_t   i_data,
	output sd_bus_pkg::word_t   o_crc_word
);

	sd_crc_pkg::crc_bank_t crc_bank;
	sd_crc_pkg::crc_bank_t start_bank;
	sd_crc_pkg::crc_bank_t next_1;
	sd_crc_pkg::crc_bank_t next_4;
	sd_crc_pkg::crc_bank_t next_8;
	sd_crc_pkg::crc_bank_t next_bank;

	////////////////////////////////////////////////////////////////////////////
	// Word update
	////////////////////////////////////////////////////////////////////////////

	// Active lines fill the top of the bank, line j bit b at base + b*lanes + j,
	// everything below is held at one
	function automatic sd_crc_pkg::crc_bank_t advance_bank(
		input sd_crc_pkg::crc_bank_t bank,
		input sd_bus_pkg::word_t     data,
		input int                    lanes
	);
		sd_crc_pkg::crc_t      fill [sd_crc_pkg::MAX_LANES];
		sd_crc_pkg::crc_bank_t result;
		int                    base;
		int                    line;

		base   = sd_crc_pkg::CRC_BITS * (sd_crc_pkg::MAX_LANES - lanes);
		result = '1;

		// Sort the bank by line
		for (int j = 0; j < sd_crc_pkg::MAX_LANES; j++) begin
			fill[j] = '1;
			if (j < lanes) begin
				for (int b = 0; b < sd_crc_pkg::CRC_BITS; b++)
					fill[j][b] = bank[base + b * lanes + j];
			end
		end

		// Word bit p leaves on line p mod lanes, MSB first
		for (int p = sd_bus_pkg::WORD_BITS - 1; p >= 0; p--) begin
			line       = p % lanes;
			fill[line] = sd_crc_pkg::crc_step(fill[line], data[p]);
		end

		// And back into bus order
		for (int j = 0; j < sd_crc_pkg::MAX_LANES; j++) begin
			if (j < lanes) begin
				for (int b = 0; b < sd_crc_pkg::CRC_BITS; b++)
					result[base + b * lanes + j] = fill[j][b];
			end
		end
		return result;
	endfunction

	always_comb begin
		// First word of a frame starts from a zero fill
		start_bank = i_clear ? '0 : crc_bank;
		next_1     = advance_bank(start_bank, i_data, 1);
		next_4     = advance_bank(start_bank, i_data, 4);
		next_8     = advance_bank(start_bank, i_data, 8);

		case (i_cfg.width)
		sd_bus_pkg::WIDTH_1: next_bank = next_1;
		sd_bus_pkg::WIDTH_4: next_bank = next_4;
		default:             next_bank = next_8;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Bank register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (!i_reset)
			crc_bank <= '0;
		else if (i_advance)
			crc_bank <= next_bank;
		else if (i_shift)
			crc_bank <= {crc_bank[sd_crc_pkg::CRC_BITS*sd_crc_pkg::MAX_LANES
				- sd_bus_pkg::WORD_BITS - 1:0], sd_bus_pkg::IDLE_WORD};
	end

	// Single line gets its CRC followed by ones
	assign o_crc_word = crc_bank[sd_crc_pkg::CRC_BITS*sd_crc_pkg::MAX_LANES-1
		-: sd_bus_pkg::WORD_BITS];

endmodule

// ==== src/sd_tx_serializer.sv ====
/* Line serializer of the SD transmit path. Breaks each word into 1, 4 or 8 bit
   groups, one per clock strobe, and frames them with start and stop groups. */

`timescale 1ns/1ps

module sd_tx_serializer (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_ckstb,
	input  sd_bus_pkg::tx_cfg_t   i_cfg,
	input  sd_bus_pkg::pre_word_t i_pre,
	output logic                  o_pre_ready,
	output logic                  o_line_busy,
	output logic                  o_tx_valid,
	output sd_bus_pkg::lanes_t    o_tx_data
);

	logic               framing;
	logic               stop_pending;
	logic [4:0]         group_count;
	sd_bus_pkg::word_t  shift_reg;
	sd_bus_pkg::lanes_t line_data;
	logic               load;
	logic               advance;
	sd_bus_pkg::word_t  shift_src;
	sd_bus_pkg::word_t  next_shift;
	sd_bus_pkg::lanes_t next_group;
	sd_bus_pkg::lanes_t start_group;
	logic [4:0]         load_count;

	// Takes a new word only once the last group of the old one is out
	assign o_pre_ready = i_ckstb && (group_count == 5'd0);
	assign load        = o_pre_ready && i_pre.valid;
	assign advance     = load || (i_ckstb && group_count != 5'd0);
	assign shift_src   = load ? i_pre.data : shift_reg;

	////////////////////////////////////////////////////////////////////////////
	// Group selection
	////////////////////////////////////////////////////////////////////////////

	// Unused lines are padded high
	always_comb begin
		case (i_cfg.width)
		sd_bus_pkg::WIDTH_1: begin
			next_group  = {7'h7f, shift_src[31]};
			next_shift  = {shift_src[30:0], 1'b1};
			start_group = 8'hfe;
			load_count  = i_pre.half ? 5'd15 : 5'd31;
		end
		sd_bus_pkg::WIDTH_4: begin
			next_group  = {4'hf, shift_src[31:28]};
			next_shift  = {shift_src[27:0], 4'hf};
			start_group = 8'hf0;
			load_count  = 5'd7;
		end
		default: begin
			next_group  = shift_src[31:24];
			next_shift  = {shift_src[23:0], 8'hff};
			start_group = 8'h00;
			load_count  = 5'd3;
		end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Framing
	////////////////////////////////////////////////////////////////////////////

	// Valid rises with the start group and stays one group past the last word
	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			framing      <= 1'b0;
			stop_pending <= 1'b0;
		end else if (i_pre.start) begin
			framing      <= 1'b1;
			stop_pending <= 1'b1;
		end else if (o_pre_ready) begin
			framing      <= i_pre.valid || stop_pending;
			stop_pending <= i_pre.valid;
		end
	end

	always_ff @(posedge i_clk) begin
		if (!i_reset) begin
			line_data   <= '1;
			group_count <= 5'd0;
		end else if (load) begin
			line_data   <= next_group;
			group_count <= load_count;
		end else if (advance) begin
			line_data   <= next_group;
			group_count <= group_count - 5'd1;
		end else if (o_pre_ready) begin
			// Start group, or the stop group and idle ones
			line_data <= i_pre.start ? start_group : '1;
		end
	end

	always_ff @(posedge i_clk) begin
		if (advance)
			shift_reg <= next_shift;
	end

	assign o_line_busy = framing;
	assign o_tx_valid  = framing;
	assign o_tx_data   = line_data;

endmodule

// ==== src/sd_tx_frame.sv ====
/* Top of the SD transmit framer. Takes a word stream and drives framed data,
   per-line CRCs and a stop group onto 1, 4 or 8 data lines. */

`timescale 1ns/1ps

module sd_tx_frame (
	input  logic                    i_clk,
	input  logic                    i_reset,
	input  sd_bus_pkg::lane_width_e i_cfg_width,
	input  logic                    i_en,
	input  logic                    i_ckstb,
	input  logic                    i_s_valid,
	input  sd_bus_pkg::word_t       i_s_data,
	input  logic                    i_s_last,
	output logic                    o_s_ready,
	output logic                    o_tx_valid,
	output sd_bus_pkg::lanes_t      o_tx_data
);

	sd_bus_pkg::tx_cfg_t   cfg;
	sd_bus_pkg::pre_word_t pre;
	logic                  pre_ready;
	logic                  line_busy;
	logic                  crc_clear;
	logic                  crc_advance;
	logic                  crc_shift;
	sd_bus_pkg::word_t     crc_word;

	sd_tx_packetizer u_packetizer (
		.i_clk         (i_clk),
		.i_reset       (i_reset),
		.i_cfg_width   (i_cfg_width),
		.i_en          (i_en),
		.i_s_valid     (i_s_valid),
		.i_s_data      (i_s_data),
		.i_s_last      (i_s_last),
		.i_pre_ready   (pre_ready),
		.i_line_busy   (line_busy),
		.i_crc_word    (crc_word),
		.o_s_ready     (o_s_ready),
		.o_cfg         (cfg),
		.o_pre         (pre),
		.o_crc_clear   (crc_clear),
		.o_crc_advance (crc_advance),
		.o_crc_shift   (crc_shift)
	);

	// CRCs run over the accepted stream words directly
	sd_tx_crc_bank u_crc_bank (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_cfg      (cfg),
		.i_clear    (crc_clear),
		.i_advance  (crc_advance),
		.i_shift    (crc_shift),
		.i_data     (i_s_data),
		.o_crc_word (crc_word)
	);

	sd_tx_serializer u_serializer (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_ckstb     (i_ckstb),
		.i_cfg       (cfg),
		.i_pre       (pre),
		.o_pre_ready (pre_ready),
		.o_line_busy (line_busy),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

endmodule

// ==== sim/sd_tx_frame_tb.sv ====
/* Self-checking testbench for the SD transmit framer. Sends random frames on
   1, 4 and 8 lines and compares every line group with a reference model. */

`timescale 1ns/1ps

module sd_tx_frame_tb;

	localparam int N_FRAMES    = 40;
	localparam int CYCLE_LIMIT = N_FRAMES * 7 * 32 * 4 + 4000;

	logic                    i_clk;
	logic                    i_reset;
	sd_bus_pkg::lane_width_e i_cfg_width;
	logic                    i_en;
	logic                    i_ckstb;
	logic                    i_s_valid;
	sd_bus_pkg::word_t       i_s_data;
	logic                    i_s_last;
	logic                    o_s_ready;
	logic                    o_tx_valid;
	sd_bus_pkg::lanes_t      o_tx_data;

	// Stimulus state shared by the tasks
	logic [31:0]             rng_state;
	int                      gap_left;
	logic                    en_drive;
	sd_bus_pkg::lane_width_e cfg_drive;
	sd_bus_pkg::word_t       frame_words [6];
	sd_bus_pkg::lanes_t      exp_groups [$];
	int                      exp_lens [$];
	int                      frames_done;
	int                      errors;

	sd_tx_frame dut (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cfg_width (i_cfg_width),
		.i_en        (i_en),
		.i_ckstb     (i_ckstb),
		.i_s_valid   (i_s_valid),
		.i_s_data    (i_s_data),
		.i_s_last    (i_s_last),
		.o_s_ready   (o_s_ready),
		.o_tx_valid  (o_tx_valid),
		.o_tx_data   (o_tx_data)
	);

	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// CRC-16 with polynomial 0x1021, one bit at a time
	function automatic sd_crc_pkg::crc_t crc16_bit(input sd_crc_pkg::crc_t crc, input logic din);
		logic feedback;

		feedback = crc[15] ^ din;
		return {crc[14:0], 1'b0} ^ (feedback ? 16'h1021 : 16'h0000);
	endfunction

	// Expected groups of one frame: start, data, per-line CRC, stop
	function automatic void build_expected(input int lanes, input int n_words);
		sd_crc_pkg::crc_t   crc [8];
		sd_bus_pkg::lanes_t grp;
		int                 bit_pos;

		for (int k = 0; k < 8; k++)
			crc[k] = '0;
		grp = '1;
		for (int k = 0; k < lanes; k++)
			grp[k] = 1'b0;
		exp_groups.push_back(grp);
		// Line k sends the word bits MSB first, lanes bits per group
		for (int w = 0; w < n_words; w++) begin
			for (int g = 0; g < 32 / lanes; g++) begin
				grp = '1;
				for (int k = 0; k < lanes; k++) begin
					bit_pos = 31 - g * lanes - (lanes - 1 - k);
					grp[k]  = frame_words[w][bit_pos];
					crc[k]  = crc16_bit(crc[k], grp[k]);
				end
				exp_groups.push_back(grp);
			end
		end
		for (int b = 0; b < 16; b++) begin
			grp = '1;
			for (int k = 0; k < lanes; k++)
				grp[k] = crc[k][15 - b];
			exp_groups.push_back(grp);
		end
		exp_groups.push_back(8'hff);
		exp_lens.push_back(2 + n_words * (32 / lanes) + 16);
	endfunction

	task automatic stop_run();
		errors++;
		$display("Checks failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_error(input string why);
		$display("error at %0t ns: %s", $time, why);
		stop_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, got, want);
			stop_run();
		end
	endtask

	// One cycle of stimulus, handshake sampled mid-cycle
	task automatic step_cycle(input logic valid, input sd_bus_pkg::word_t data,
		input logic last, output logic taken);
		@(negedge i_clk);
		if (gap_left == 0) begin
			i_ckstb  = 1'b1;
			gap_left = int'((next_rand() >> 16) % 4);
		end else begin
			i_ckstb  = 1'b0;
			gap_left = gap_left - 1;
		end
		i_en        = en_drive;
		i_cfg_width = cfg_drive;
		i_s_valid   = valid;
		i_s_data    = data;
		i_s_last    = last;
		#1;
		// Words move only on a strobe
		if (!i_ckstb)
			check_value("o_s_ready", o_s_ready, 0);
		taken = valid && o_s_ready;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		logic                    taken;
		logic [31:0]             r_hi;
		logic [31:0]             r_lo;
		int                      n_words;
		int                      lanes;
		int                      w;
		sd_bus_pkg::lane_width_e width;

		i_reset     = 1'b0;
		i_cfg_width = sd_bus_pkg::WIDTH_1;
		i_en        = 1'b0;
		i_ckstb     = 1'b0;
		i_s_valid   = 1'b0;
		i_s_data    = '0;
		i_s_last    = 1'b0;
		rng_state   = 32'd63440;
		gap_left    = 0;
		en_drive    = 1'b0;
		cfg_drive   = sd_bus_pkg::WIDTH_1;
		frames_done = 0;
		errors      = 0;
		repeat (10) @(negedge i_clk);
		i_reset = 1'b1;

		// Disabled framer ignores a waiting word
		repeat (24) begin
			step_cycle(1'b1, 32'h1234_5678, 1'b1, taken);
			check_value("o_s_ready", o_s_ready, 0);
			check_value("o_tx_valid", o_tx_valid, 0);
			check_value("o_tx_data", o_tx_data, 8'hff);
		end
		en_drive = 1'b1;

		for (int f = 0; f < N_FRAMES; f++) begin
			width     = sd_bus_pkg::lane_width_e'(f % 3);
			lanes     = (width == sd_bus_pkg::WIDTH_1) ? 1
				: (width == sd_bus_pkg::WIDTH_4) ? 4 : 8;
			cfg_drive = width;
			n_words   = 1 + int'((next_rand() >> 16) % 6);
			for (int i = 0; i < n_words; i++) begin
				r_hi = next_rand();
				r_lo = next_rand();
				frame_words[i] = (f == 2) ? '1 : {r_hi[31:16], r_lo[31:16]};
			end
			build_expected(lanes, n_words);
			// Let the idle framer pick up the new width
			repeat (4) step_cycle(1'b0, '0, 1'b0, taken);

			w = 0;
			while (w < n_words) begin
				step_cycle(1'b1, frame_words[w], w == n_words - 1, taken);
				if (taken) begin
					// Width changes after the start must not reach this frame
					if (w == 0)
						cfg_drive = sd_bus_pkg::lane_width_e'((f + 1) % 3);
					w++;
				end
			end
			step_cycle(1'b0, '0, 1'b0, taken);
			while (o_tx_valid) begin
				// No word is taken while the CRC and stop groups go out
				check_value("o_s_ready", o_s_ready, 0);
				step_cycle(1'b0, '0, 1'b0, taken);
			end
		end

		repeat (8) step_cycle(1'b0, '0, 1'b0, taken);
		check_value("frames checked", frames_done, N_FRAMES);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// Output compare
	////////////////////////////////////////////////////////////////////////////

	initial begin : compare
		logic               strobed;
		logic               last_valid;
		sd_bus_pkg::lanes_t last_data;
		logic               in_frame;
		int                 count;

		in_frame   = 1'b0;
		count      = 0;
		last_valid = 1'b0;
		last_data  = '1;
		wait (i_reset === 1'b1);
		forever begin
			@(posedge i_clk);
			strobed = i_ckstb;
			@(negedge i_clk);
			if (!strobed) begin
				// Nothing moves without a strobe
				check_value("o_tx_valid", o_tx_valid, last_valid);
				check_value("o_tx_data", o_tx_data, last_data);
			end else if (o_tx_valid) begin
				if (!in_frame && exp_lens.size() == 0) begin
					report_error("o_tx_valid rose with no frame sent");
				end else if (in_frame && count >= exp_lens[0]) begin
					report_error("frame is longer than expected");
				end else begin
					in_frame = 1'b1;
					check_value("o_tx_data", o_tx_data, exp_groups.pop_front());
					count++;
				end
			end else begin
				if (in_frame) begin
					check_value("frame length", count, exp_lens.pop_front());
					frames_done++;
				end
				in_frame = 1'b0;
				count    = 0;
				check_value("o_tx_data", o_tx_data, 8'hff);
			end
			last_valid = o_tx_valid;
			last_data  = o_tx_data;
		end
	end

	initial begin : watchdog
		int cycles;

		cycles = 0;
		forever begin
			@(posedge i_clk);
			cycles++;
			if (cycles >= CYCLE_LIMIT)
				report_error("run did not finish within the cycle limit");
		end
	end

endmodule

// ==== build.f ====
src/sd_bus_pkg.sv
src/sd_crc_pkg.sv
src/sd_tx_packetizer.sv
src/sd_tx_crc_bank.sv
src/sd_tx_serializer.sv
src/sd_tx_frame.sv
sim/sd_tx_frame_tb.sv
